/* common/rename_pkg.sv */
`default_nettype none

package rename_pkg;

    localparam int NUM_LANES = 2;
    localparam int NUM_CHECKPOINTS = 4;

    typedef logic [4:0] areg_t;
    // wide enough for the largest supported physical file
    typedef logic [6:0] preg_t;
    typedef logic [1:0] ckpt_idx_t;

    // counts of free registers and of free checkpoint slots
    typedef logic [$bits(preg_t):0] preg_cnt_t;
    typedef logic [$clog2(NUM_CHECKPOINTS):0] ckpt_cnt_t;

    typedef enum logic [1:0] {
        ALU,
        LOAD,
        STORE,
        CTRL_FLOW
    } fu_t;

    typedef struct packed {
        fu_t   fu;
        areg_t rs1;
        areg_t rs2;
        areg_t rd;
        logic  has_rd;
    } decoded_instr_t;

    // one decode lane with its valid strobe
    typedef struct packed {
        logic           valid;
        decoded_instr_t instr;
    } decode_lane_t;

    typedef struct packed {
        fu_t       fu;
        preg_t     ps1;
        preg_t     ps2;
        preg_t     pd;
        preg_t     prev_pd;
        ckpt_idx_t ckpt;
        logic      valid;
    } renamed_instr_t;

    typedef struct packed {
        logic  valid;
        preg_t preg;
    } commit_t;

    typedef struct packed {
        logic      valid;
        logic      mispredict;
        ckpt_idx_t ckpt;
    } resolve_t;

    // x0 is never renamed
    function automatic logic needs_preg(decode_lane_t lane);
        return lane.valid && lane.instr.has_rd && (lane.instr.rd != '0);
    endfunction

    function automatic logic is_branch(decode_lane_t lane);
        return lane.valid && (lane.instr.fu == CTRL_FLOW);
    endfunction

endpackage

`default_nettype wire

/* free_list/free_list.sv */
`timescale 1ns/1ps
`default_nettype none

module free_list #(
    parameter int NUM_PREGS = 128,
    parameter int NUM_AREGS = 32
) (
    input  wire logic                                            clk_i,
    input  wire logic                                            rst_ni,
    input  wire logic                                            alloc_en_i,
    input  wire logic [rename_pkg::NUM_LANES-1:0]                alloc_need_i,
    output rename_pkg::preg_t [rename_pkg::NUM_LANES-1:0]        new_preg_o,
    output rename_pkg::preg_t [rename_pkg::NUM_LANES-1:0]        rd_ptr_o,
    output rename_pkg::preg_cnt_t                                free_count_o,
    input  wire rename_pkg::commit_t [rename_pkg::NUM_LANES-1:0] commit_i,
    input  wire logic                                            restore_en_i,
    input  wire rename_pkg::preg_t                               restore_ptr_i
);

    localparam int FREE_INIT = NUM_PREGS - NUM_AREGS;

    rename_pkg::preg_t [NUM_PREGS-1:0] fl_q;
    rename_pkg::preg_t [NUM_PREGS-1:0] fl_n;
    rename_pkg::preg_t                 rd_q;
    rename_pkg::preg_t                 rd_n;
    rename_pkg::preg_t                 wr_q;
    rename_pkg::preg_t                 wr_n;

    // pointer step with wrap at NUM_PREGS
    function automatic rename_pkg::preg_t ptr_add(rename_pkg::preg_t ptr, int step);
        int sum;
        sum = int'(ptr) + step;
        if (sum >= NUM_PREGS)
        begin
            sum = sum - NUM_PREGS;
        end
        return rename_pkg::preg_t'(sum);
    endfunction

    always_comb
    begin
        int slot;
        int cnt;
        // commits land first, so a freed register can be handed out in the same cycle
        fl_n = fl_q;
        wr_n = wr_q;
        for (int l = 0; l < rename_pkg::NUM_LANES; l++)
        begin
            if (commit_i[l].valid)
            begin
                fl_n[wr_n] = commit_i[l].preg;
                wr_n = ptr_add(wr_n, 1);
            end
        end

        // reads in lane order
        slot = 0;
        for (int l = 0; l < rename_pkg::NUM_LANES; l++)
        begin
            new_preg_o[l] = fl_n[ptr_add(rd_q, slot)];
            if (alloc_need_i[l])
            begin
                slot = slot + 1;
            end
            rd_ptr_o[l] = ptr_add(rd_q, slot);
        end

        if (restore_en_i)
        begin
            rd_n = restore_ptr_i;
        end
        else if (alloc_en_i)
        begin
            rd_n = rd_ptr_o[rename_pkg::NUM_LANES-1];
        end
        else
        begin
            rd_n = rd_q;
        end

        // count is only ever derived from the pointers
        cnt = int'(wr_q) - int'(rd_q);
        if (cnt < 0)
        begin
            cnt = cnt + NUM_PREGS;
        end
        free_count_o = rename_pkg::preg_cnt_t'(cnt);
    end

    always_ff @(posedge clk_i)
    begin
        if (!rst_ni)
        begin
            rd_q <= '0;
            wr_q <= rename_pkg::preg_t'(FREE_INIT);
            for (int i = 0; i < FREE_INIT; i++)
            begin
                fl_q[i] <= rename_pkg::preg_t'(NUM_AREGS + i);
            end
        end
        else
        begin
            rd_q <= rd_n;
            wr_q <= wr_n;
            fl_q <= fl_n;
        end
    end

endmodule

`default_nettype wire

/* map_table/map_table.sv */
`timescale 1ns/1ps
`default_nettype none

module map_table #(
    parameter int NUM_AREGS = 32
) (
    input  wire logic                                                 clk_i,
    input  wire logic                                                 rst_ni,
    input  wire logic                                                 alloc_en_i,
    input  wire rename_pkg::decode_lane_t [rename_pkg::NUM_LANES-1:0] decode_i,
    input  wire rename_pkg::preg_t [rename_pkg::NUM_LANES-1:0]        new_preg_i,
    output rename_pkg::renamed_instr_t [rename_pkg::NUM_LANES-1:0]    renamed_o,
    output rename_pkg::preg_t [rename_pkg::NUM_LANES-1:0][NUM_AREGS-1:0] snapshot_o,
    input  wire logic                                                 restore_en_i,
    input  wire rename_pkg::preg_t [NUM_AREGS-1:0]                    restore_table_i
);

    rename_pkg::preg_t [NUM_AREGS-1:0] map_q;
    rename_pkg::preg_t [NUM_AREGS-1:0] work;

    // lanes walk the table in order, so later lanes see earlier destinations
    always_comb
    begin
        work = map_q;
        for (int l = 0; l < rename_pkg::NUM_LANES; l++)
        begin
            renamed_o[l] = '0;
            renamed_o[l].valid = decode_i[l].valid;
            renamed_o[l].fu = decode_i[l].instr.fu;
            renamed_o[l].ps1 = work[decode_i[l].instr.rs1];
            renamed_o[l].ps2 = work[decode_i[l].instr.rs2];
            if (rename_pkg::needs_preg(decode_i[l]))
            begin
                renamed_o[l].prev_pd = work[decode_i[l].instr.rd];
                renamed_o[l].pd = new_preg_i[l];
                work[decode_i[l].instr.rd] = new_preg_i[l];
            end
            else
            begin
                // x0 or no destination
                renamed_o[l].prev_pd = '0;
                renamed_o[l].pd = '0;
            end
            snapshot_o[l] = work;
        end
    end

    always_ff @(posedge clk_i)
    begin
        if (!rst_ni)
        begin
            // identity map out of reset
            for (int r = 0; r < NUM_AREGS; r++)
            begin
                map_q[r] <= rename_pkg::preg_t'(r);
            end
        end
        else if (restore_en_i)
        begin
            map_q <= restore_table_i;
        end
        else if (alloc_en_i)
        begin
            map_q <= snapshot_o[rename_pkg::NUM_LANES-1];
        end
    end

endmodule

`default_nettype wire

/* design/checkpoint_store.sv */
`timescale 1ns/1ps
`default_nettype none

module checkpoint_store #(
    parameter int NUM_AREGS = 32
) (
    input  wire logic                                                 clk_i,
    input  wire logic                                                 rst_ni,
    input  wire logic                                                 alloc_en_i,
    input  wire rename_pkg::decode_lane_t [rename_pkg::NUM_LANES-1:0] decode_i,
    input  wire rename_pkg::preg_t [rename_pkg::NUM_LANES-1:0][NUM_AREGS-1:0] snapshot_i,
    input  wire rename_pkg::preg_t [rename_pkg::NUM_LANES-1:0]        rd_ptr_i,
    output rename_pkg::ckpt_idx_t [rename_pkg::NUM_LANES-1:0]         ckpt_o,
    output rename_pkg::ckpt_cnt_t                                     slots_free_o,
    input  wire rename_pkg::resolve_t                                 resolve_i,
    output rename_pkg::preg_t [NUM_AREGS-1:0]                         restore_table_o,
    output rename_pkg::preg_t                                         restore_ptr_o
);

    typedef struct packed {
        rename_pkg::preg_t [NUM_AREGS-1:0] map;
        rename_pkg::preg_t                 rd_ptr;
    } ckpt_entry_t;

    ckpt_entry_t [rename_pkg::NUM_CHECKPOINTS-1:0] ring_q;
    rename_pkg::ckpt_idx_t                         tail_q;
    rename_pkg::ckpt_idx_t                         tail_n;
    rename_pkg::ckpt_cnt_t                         count_q;
    rename_pkg::ckpt_cnt_t                         count_n;
    logic [rename_pkg::NUM_LANES-1:0]              push;
    logic                                          pop;
    logic                                          flush;

    assign pop = resolve_i.valid && !resolve_i.mispredict;
    assign flush = resolve_i.valid && resolve_i.mispredict;

    always_comb
    begin
        tail_n = tail_q;
        count_n = count_q;
        for (int l = 0; l < rename_pkg::NUM_LANES; l++)
        begin
            push[l] = alloc_en_i && rename_pkg::is_branch(decode_i[l]);
            ckpt_o[l] = tail_n;
            if (push[l])
            begin
                tail_n = tail_n + 1'b1;
                count_n = count_n + 1'b1;
            end
        end
        // oldest branch resolved correctly
        if (pop)
        begin
            count_n = count_n - 1'b1;
        end
    end

    assign slots_free_o = rename_pkg::ckpt_cnt_t'(rename_pkg::NUM_CHECKPOINTS) - count_q;
    assign restore_table_o = ring_q[resolve_i.ckpt].map;
    assign restore_ptr_o = ring_q[resolve_i.ckpt].rd_ptr;

    always_ff @(posedge clk_i)
    begin
        if (!rst_ni)
        begin
            tail_q <= '0;
            count_q <= '0;
        end
        else if (flush)
        begin
            // younger branches are squashed along with the one that missed
            tail_q <= '0;
            count_q <= '0;
        end
        else
        begin
            tail_q <= tail_n;
            count_q <= count_n;
        end
    end

    always_ff @(posedge clk_i)
    begin
        for (int l = 0; l < rename_pkg::NUM_LANES; l++)
        begin
            if (push[l])
            begin
                ring_q[ckpt_o[l]] <= '{map: snapshot_i[l], rd_ptr: rd_ptr_i[l]};
            end
        end
    end

endmodule

`default_nettype wire

/* design/rename_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module rename_stage #(
    parameter int NUM_PREGS = 128,
    parameter int NUM_AREGS = 32
) (
    input  wire logic                                               clk_i,
    input  wire logic                                               rst_ni,
    input  wire rename_pkg::decode_lane_t [rename_pkg::NUM_LANES-1:0] decode_i,
    output logic                                                    ack_o,
    input  wire rename_pkg::commit_t [rename_pkg::NUM_LANES-1:0]    commit_i,
    input  wire rename_pkg::resolve_t                               resolve_i,
    output rename_pkg::renamed_instr_t [rename_pkg::NUM_LANES-1:0]  renamed_o,
    input  wire logic                                               issue_ack_i
);

    localparam int L = rename_pkg::NUM_LANES;

    logic                                        alloc_en;
    logic                                        mispredict;
    logic [L-1:0]                                alloc_need;
    rename_pkg::preg_t [L-1:0]                   new_preg;
    rename_pkg::preg_t [L-1:0]                   rd_ptr;
    rename_pkg::preg_cnt_t                       free_count;
    rename_pkg::renamed_instr_t [L-1:0]          mt_renamed;
    rename_pkg::preg_t [L-1:0][NUM_AREGS-1:0]    snapshot;
    rename_pkg::ckpt_idx_t [L-1:0]               ckpt;
    rename_pkg::ckpt_cnt_t                       slots_free;
    rename_pkg::preg_t [NUM_AREGS-1:0]           restore_table;
    rename_pkg::preg_t                           restore_ptr;

    rename_pkg::preg_cnt_t                       need_cnt;
    rename_pkg::preg_cnt_t                       commit_cnt;
    rename_pkg::ckpt_cnt_t                       br_cnt;
    logic                                        any_valid;
    logic                                        out_valid;
    rename_pkg::renamed_instr_t [L-1:0]          renamed_d;
    rename_pkg::renamed_instr_t [L-1:0]          out_q;

    assign mispredict = resolve_i.valid && resolve_i.mispredict;

    // group demand on registers and checkpoints
    always_comb
    begin
        need_cnt = '0;
        commit_cnt = '0;
        br_cnt = '0;
        any_valid = 1'b0;
        out_valid = 1'b0;
        for (int l = 0; l < L; l++)
        begin
            alloc_need[l] = rename_pkg::needs_preg(decode_i[l]);
            if (alloc_need[l])
            begin
                need_cnt = need_cnt + 1'b1;
            end
            if (rename_pkg::is_branch(decode_i[l]))
            begin
                br_cnt = br_cnt + 1'b1;
            end
            if (commit_i[l].valid)
            begin
                commit_cnt = commit_cnt + 1'b1;
            end
            any_valid = any_valid || decode_i[l].valid;
            out_valid = out_valid || out_q[l].valid;
        end
    end

    // lanes are taken together or not at all
    assign ack_o = any_valid
                && (free_count + commit_cnt >= need_cnt)
                && (br_cnt <= slots_free)
                && (!out_valid || issue_ack_i)
                && !mispredict;

    assign alloc_en = ack_o;

    free_list #(
        .NUM_PREGS (NUM_PREGS),
        .NUM_AREGS (NUM_AREGS)
    ) u_free_list (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .alloc_en_i    (alloc_en),
        .alloc_need_i  (alloc_need),
        .new_preg_o    (new_preg),
        .rd_ptr_o      (rd_ptr),
        .free_count_o  (free_count),
        .commit_i      (commit_i),
        .restore_en_i  (mispredict),
        .restore_ptr_i (restore_ptr)
    );

    map_table #(
        .NUM_AREGS (NUM_AREGS)
    ) u_map_table (
        .clk_i           (clk_i),
        .rst_ni          (rst_ni),
        .alloc_en_i      (alloc_en),
        .decode_i        (decode_i),
        .new_preg_i      (new_preg),
        .renamed_o       (mt_renamed),
        .snapshot_o      (snapshot),
        .restore_en_i    (mispredict),
        .restore_table_i (restore_table)
    );

    checkpoint_store #(
        .NUM_AREGS (NUM_AREGS)
    ) u_checkpoint_store (
        .clk_i           (clk_i),
        .rst_ni          (rst_ni),
        .alloc_en_i      (alloc_en),
        .decode_i        (decode_i),
        .snapshot_i      (snapshot),
        .rd_ptr_i        (rd_ptr),
        .ckpt_o          (ckpt),
        .slots_free_o    (slots_free),
        .resolve_i       (resolve_i),
        .restore_table_o (restore_table),
        .restore_ptr_o   (restore_ptr)
    );

    always_comb
    begin
        for (int l = 0; l < L; l++)
        begin
            renamed_d[l] = mt_renamed[l];
            renamed_d[l].ckpt = ckpt[l];
        end
    end

    // output register, held under back-pressure
    always_ff @(posedge clk_i)
    begin
        if (!rst_ni)
        begin
            out_q <= '0;
        end
        else if (mispredict)
        begin
            for (int l = 0; l < L; l++)
            begin
                out_q[l].valid <= 1'b0;
            end
        end
        else if (alloc_en)
        begin
            out_q <= renamed_d;
        end
        else if (issue_ack_i)
        begin
            for (int l = 0; l < L; l++)
            begin
                out_q[l].valid <= 1'b0;
            end
        end
    end

    assign renamed_o = out_q;

endmodule

`default_nettype wire

/* sim/rename_properties.sv */
`timescale 1ns/1ps
`default_nettype none

module rename_properties (
    input wire logic                                                  clk_i,
    input wire logic                                                  rst_ni,
    input wire logic                                                  ack_i,
    input wire logic                                                  issue_ack_i,
    input wire logic                                                  out_valid_i,
    input wire logic                                                  mispredict_i,
    input wire rename_pkg::preg_cnt_t                                 free_count_i,
    input wire rename_pkg::decode_lane_t [rename_pkg::NUM_LANES-1:0]  decode_i,
    input wire rename_pkg::commit_t [rename_pkg::NUM_LANES-1:0]       commit_i,
    input wire rename_pkg::renamed_instr_t [rename_pkg::NUM_LANES-1:0] renamed_i
);

    int dest_wanted;
    int regs_avail;

    // destinations other than x0, against free entries plus this cycle's returns
    always_comb
    begin
        dest_wanted = 0;
        regs_avail = int'(free_count_i);
        for (int l = 0; l < rename_pkg::NUM_LANES; l++)
        begin
            if (decode_i[l].valid && decode_i[l].instr.has_rd
                && (decode_i[l].instr.rd != 5'd0))
            begin
                dest_wanted = dest_wanted + 1;
            end
            if (commit_i[l].valid)
            begin
                regs_avail = regs_avail + 1;
            end
        end
    end

    a_reset_clears: assert property (@(posedge clk_i)
        !rst_ni |=> !renamed_i[0].valid && !renamed_i[1].valid)
        else $error("output valid right after reset");

    // stalled output must not move
    a_hold_stalled: assert property (@(posedge clk_i) disable iff (!rst_ni)
        out_valid_i && !issue_ack_i && !mispredict_i |=> $stable(renamed_i))
        else $error("output changed under back-pressure");

    a_enough_free: assert property (@(posedge clk_i) disable iff (!rst_ni)
        ack_i |-> (regs_avail >= dest_wanted))
        else $error("group accepted without enough free registers");

endmodule

`default_nettype wire

/* sim/rename_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module rename_checker (
    input  wire logic                                                  clk_i,
    input  wire logic                                                  check_en_i,
    input  wire logic                                                  exp_ack_i,
    input  wire rename_pkg::renamed_instr_t [rename_pkg::NUM_LANES-1:0] exp_renamed_i,
    input  wire logic                                                  ack_i,
    input  wire rename_pkg::renamed_instr_t [rename_pkg::NUM_LANES-1:0] renamed_i,
    output int                                                         error_count_o,
    output int                                                         check_count_o
);

    initial
    begin
        error_count_o = 0;
        check_count_o = 0;
    end

    task automatic check_field(string name, int lane, int got, int exp);
        check_count_o++;
        if (got != exp)
        begin
            error_count_o++;
            $display("Fail %0t: lane %0d %s is %0h, expected %0h", $time, lane, name, got, exp);
        end
    endtask

    task automatic check_lane(int l);
        check_field("valid", l, renamed_i[l].valid, exp_renamed_i[l].valid);
        // payload only matters on a valid lane
        if (exp_renamed_i[l].valid)
        begin
            check_field("fu", l, renamed_i[l].fu, exp_renamed_i[l].fu);
            check_field("ps1", l, renamed_i[l].ps1, exp_renamed_i[l].ps1);
            check_field("ps2", l, renamed_i[l].ps2, exp_renamed_i[l].ps2);
            check_field("pd", l, renamed_i[l].pd, exp_renamed_i[l].pd);
            check_field("prev_pd", l, renamed_i[l].prev_pd, exp_renamed_i[l].prev_pd);
            check_field("ckpt", l, renamed_i[l].ckpt, exp_renamed_i[l].ckpt);
        end
    endtask

    // mid-cycle, well away from both driver and clock edge
    always @(negedge clk_i)
    begin
        if (check_en_i)
        begin
            check_count_o++;
            if (ack_i != exp_ack_i)
            begin
                error_count_o++;
                $display("Fail %0t: ack_o is %0b, expected %0b", $time, ack_i, exp_ack_i);
            end
            for (int l = 0; l < rename_pkg::NUM_LANES; l++)
            begin
                check_lane(l);
            end
        end
    end

endmodule

`default_nettype wire

/* sim/tb_rename_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_rename_stage;

    localparam int NUM_PREGS = 40;
    localparam int NUM_AREGS = 32;
    localparam int FIELDS = 33;
    localparam int L = rename_pkg::NUM_LANES;

    logic                                clk_i;
    logic                                rst_ni;
    rename_pkg::decode_lane_t [L-1:0]    decode;
    rename_pkg::commit_t [L-1:0]         commit;
    rename_pkg::resolve_t                resolve;
    logic                                issue_ack;
    logic                                ack;
    rename_pkg::renamed_instr_t [L-1:0]  renamed;
    rename_pkg::renamed_instr_t [L-1:0]  exp_renamed;
    logic                                exp_ack;
    logic                                check_en;
    int                                  error_count;
    int                                  check_count;
    int                                  steps;
    logic [7:0]                          trace_mem [0:1023];
    // unit class of the group the output register holds
    rename_pkg::fu_t                     out_fu [L];

    // small file so exhaustion is reached in a few steps
    rename_stage #(
        .NUM_PREGS (NUM_PREGS),
        .NUM_AREGS (NUM_AREGS)
    ) uut (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .decode_i    (decode),
        .ack_o       (ack),
        .commit_i    (commit),
        .resolve_i   (resolve),
        .renamed_o   (renamed),
        .issue_ack_i (issue_ack)
    );

    rename_checker u_checker (
        .clk_i         (clk_i),
        .check_en_i    (check_en),
        .exp_ack_i     (exp_ack),
        .exp_renamed_i (exp_renamed),
        .ack_i         (ack),
        .renamed_i     (renamed),
        .error_count_o (error_count),
        .check_count_o (check_count)
    );

    bind rename_stage rename_properties u_properties (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .ack_i        (ack_o),
        .issue_ack_i  (issue_ack_i),
        .out_valid_i  (out_valid),
        .mispredict_i (mispredict),
        .free_count_i (free_count),
        .decode_i     (decode_i),
        .commit_i     (commit_i),
        .renamed_i    (renamed_o)
    );

    function automatic logic [7:0] field(int step, int idx);
        return trace_mem[1 + step * FIELDS + idx];
    endfunction

    task automatic apply_step(int k);
        int b;
        for (int l = 0; l < L; l++)
        begin
            b = l * 6;
            decode[l].valid = 1'(field(k, b));
            decode[l].instr.fu = rename_pkg::fu_t'(2'(field(k, b + 1)));
            decode[l].instr.rs1 = rename_pkg::areg_t'(field(k, b + 2));
            decode[l].instr.rs2 = rename_pkg::areg_t'(field(k, b + 3));
            decode[l].instr.rd = rename_pkg::areg_t'(field(k, b + 4));
            decode[l].instr.has_rd = 1'(field(k, b + 5));
            commit[l].valid = 1'(field(k, 12 + l * 2));
            commit[l].preg = rename_pkg::preg_t'(field(k, 13 + l * 2));
            b = 21 + l * 6;
            exp_renamed[l] = '0;
            exp_renamed[l].valid = 1'(field(k, b));
            exp_renamed[l].fu = out_fu[l];
            exp_renamed[l].ps1 = rename_pkg::preg_t'(field(k, b + 1));
            exp_renamed[l].ps2 = rename_pkg::preg_t'(field(k, b + 2));
            exp_renamed[l].pd = rename_pkg::preg_t'(field(k, b + 3));
            exp_renamed[l].prev_pd = rename_pkg::preg_t'(field(k, b + 4));
            exp_renamed[l].ckpt = rename_pkg::ckpt_idx_t'(field(k, b + 5));
        end
        resolve.valid = 1'(field(k, 16));
        resolve.mispredict = 1'(field(k, 17));
        resolve.ckpt = rename_pkg::ckpt_idx_t'(field(k, 18));
        issue_ack = 1'(field(k, 19));
        exp_ack = 1'(field(k, 20));
    endtask

    initial
    begin
        clk_i = 1'b0;
        forever
        begin
            #5 clk_i = ~clk_i;
        end
    end

    initial
    begin
        rst_ni = 1'b0;
        decode = '0;
        commit = '0;
        resolve = '0;
        issue_ack = 1'b0;
        exp_ack = 1'b0;
        exp_renamed = '0;
        check_en = 1'b0;
        for (int l = 0; l < L; l++)
        begin
            out_fu[l] = rename_pkg::ALU;
        end
        $readmemh("sim/rename_trace.txt", trace_mem);
        steps = int'(trace_mem[0]);
        repeat (10) @(posedge clk_i);
        #1 rst_ni = 1'b1;
        for (int k = 0; k < steps; k++)
        begin
            apply_step(k);
            check_en = 1'b1;
            @(posedge clk_i);
            #1;
            // an accepted group shows up on the output next
            if (exp_ack)
            begin
                for (int l = 0; l < L; l++)
                begin
                    out_fu[l] = decode[l].instr.fu;
                end
            end
        end
        check_en = 1'b0;
        decode = '0;
        commit = '0;
        resolve = '0;
        $display("checks: %0d  errors: %0d", check_count, error_count);
        if (error_count == 0)
        begin
            $display("No errors");
        end
        else
        begin
            $display("Errors found");
        end
        $finish;
    end

    // budget of 20 cycles per step on top of reset
    initial
    begin
        #1;
        #((steps * 20 + 10) * 10);
        $display("simulation timed out after %0d steps budget", steps);
        $display("Errors found");
        $finish;
    end

endmodule

`default_nettype wire

/* sim/rename_trace.txt */
// first word is the step count, then one step per line, all hex
// lane0 v fu rs1 rs2 rd has_rd | lane1 same | c0 v preg c1 v preg | resolve v mis ckpt |
// issue_ack | exp ack | exp out lane0 v ps1 ps2 pd prev ckpt | exp out lane1 same
14
1 0 01 02 03 1  1 0 04 05 06 1  0 00 0 00  0 0 0  1  1  0 00 00 00 00 0  0 00 00 00 00 0
1 0 03 00 07 1  1 0 07 06 00 1  0 00 0 00  0 0 0  1  1  1 01 02 20 03 0  1 04 05 21 06 0
1 0 07 00 08 1  0 0 00 00 00 0  0 00 0 00  0 0 0  0  0  1 20 00 22 07 0  1 22 21 00 00 0
1 0 07 00 08 1  0 0 00 00 00 0  0 00 0 00  0 0 0  0  0  1 20 00 22 07 0  1 22 21 00 00 0
1 0 07 00 08 1  0 0 00 00 00 0  0 00 0 00  0 0 0  1  1  1 20 00 22 07 0  1 22 21 00 00 0
1 0 01 01 09 1  1 0 01 01 0a 1  0 00 0 00  0 0 0  1  1  1 22 00 23 08 0  0 00 00 00 00 0
1 0 01 01 0b 1  1 0 01 01 0c 1  0 00 0 00  0 0 0  1  1  1 01 01 24 09 0  1 01 01 25 0a 0
1 0 01 01 0d 1  0 0 00 00 00 0  0 00 0 00  0 0 0  1  0  1 01 01 26 0b 0  1 01 01 27 0c 0
1 0 01 01 0d 1  0 0 00 00 00 0  1 03 0 00  0 0 0  1  1  0 00 00 00 00 0  0 00 00 00 00 0
1 3 0d 03 00 0  0 0 00 00 00 0  1 14 1 15  0 0 0  1  1  1 01 01 03 0d 0  0 00 00 00 00 0
1 0 0d 03 0d 1  1 0 0d 00 03 1  0 00 0 00  0 0 0  1  1  1 03 20 00 00 0  0 00 00 00 00 0
1 0 01 01 05 1  0 0 00 00 00 0  0 00 0 00  1 1 0  1  0  1 03 20 14 03 1  1 14 00 15 20 1
1 0 0d 03 0d 1  1 0 0d 00 03 1  0 00 0 00  0 0 0  1  1  0 00 00 00 00 0  0 00 00 00 00 0
1 3 00 00 00 0  1 3 00 00 00 0  0 00 0 00  0 0 0  1  1  1 03 20 14 03 0  1 14 00 15 20 0
1 3 00 00 00 0  1 3 00 00 00 0  0 00 0 00  0 0 0  1  1  1 00 00 00 00 0  1 00 00 00 00 1
1 3 00 00 00 0  0 0 00 00 00 0  0 00 0 00  0 0 0  1  0  1 00 00 00 00 2  1 00 00 00 00 3
1 3 00 00 00 0  0 0 00 00 00 0  0 00 0 00  1 0 0  1  0  0 00 00 00 00 0  0 00 00 00 00 0
1 3 00 00 00 0  0 0 00 00 00 0  0 00 0 00  0 0 0  1  1  0 00 00 00 00 0  0 00 00 00 00 0
0 0 00 00 00 0  0 0 00 00 00 0  0 00 0 00  0 0 0  1  0  1 00 00 00 00 0  0 00 00 00 00 0
0 0 00 00 00 0  0 0 00 00 00 0  0 00 0 00  0 0 0  1  0  0 00 00 00 00 0  0 00 00 00 00 0

/* rename_stage.f */
common/rename_pkg.sv
free_list/free_list.sv
map_table/map_table.sv
design/checkpoint_store.sv
design/rename_stage.sv
sim/rename_properties.sv
sim/rename_checker.sv
sim/tb_rename_stage.sv

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_rename_stage \
    -f rename_stage.f -Mdir obj_dir -o sim_rename > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "build failed"
    exit 1
fi

./obj_dir/sim_rename > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Errors found" sim.log; then
    exit 1
fi
exit 0
